//--- Bender.yml
package:
  name: raw_pack

sources:
  - include_dirs:
      - include
    files:
      - rtl/raw_pack_pkg.sv
      - rtl/raw_lane_dispatch.sv
      - rtl/raw_to_32.sv
      - rtl/lane_fifo.sv
      - rtl/word_collector.sv
      - rtl/raw_pack_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/raw_pack_checker.sv
      - sim/raw_pack_tb.sv

//--- include/raw_pack_macros.svh
// shared constants for the raw stream packer
// include wherever tag codes, widths or lane count are needed

`ifndef RAW_PACK_MACROS_SVH
`define RAW_PACK_MACROS_SVH

// data type tag
`define DTYPE_WIDTH     3
`define DTYPE_HEADER    3'd1
`define DTYPE_PIXEL     3'd2
`define DTYPE_ROW_END   3'd3
`define DTYPE_FRAME_END 3'd4

// beat and word payload widths
`define RAW_WIDTH       16
`define WORD_WIDTH      32

// lanes, one packer and one fifo each
`define NUM_LANES       4
`define LANE_WIDTH      2   // log2 of NUM_LANES

// words per lane fifo
`define FIFO_DEPTH      8

// header beat index (from 0 in a header run) replaced by image_type
`define IMAGE_TYPE_POS  2

`endif

//--- rtl/lane_fifo.sv
// per-lane word fifo between a packer and the collector
// room2 tells the packer that two more pushes fit

`timescale 1ns/100ps
`default_nettype none

`include "raw_pack_macros.svh"

module lane_fifo
    import raw_pack_pkg::*;
(
    input  logic         clk,
    input  logic         resetb,

    input  logic         push,
    input  packed_word_t push_word,
    output logic         room2,

    input  logic         pop,
    output logic         not_empty,
    output packed_word_t head_word
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    packed_word_t     mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;        // one bit wider to hold a full count

    assign not_empty = (count != '0);
    assign room2     = (count <= (PTR_W+1)'(`FIFO_DEPTH - 2));
    assign head_word = mem[rd_ptr];

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage, written at the tail
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_word;
    end

endmodule

`default_nettype wire

//--- rtl/raw_lane_dispatch.sv
// steers each input beat to the packer of the lane it names
// purely combinational, ready comes back from the addressed lane

`timescale 1ns/100ps
`default_nettype none

`include "raw_pack_macros.svh"

module raw_lane_dispatch
    import raw_pack_pkg::*;
(
    input  raw_beat_t in_beat,
    input  logic      in_valid,
    output logic      in_ready,

    output logic      lane_valid [`NUM_LANES],
    input  logic      lane_ready [`NUM_LANES],
    output raw_beat_t lane_beat
);

    // one-hot valid from the lane field
    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            lane_valid[i] = in_valid && (in_beat.lane == `LANE_WIDTH'(i));
        end
    end

    // source stalls only on the lane it is currently addressing
    assign in_ready = lane_ready[in_beat.lane];

    assign lane_beat = in_beat;   // payload fans out to every lane

endmodule

`default_nettype wire

//--- rtl/raw_pack_pkg.sv
// types shared by the dispatcher, lane packers, fifos and collector
// widths come from the macros header

`default_nettype none

`include "raw_pack_macros.svh"

package raw_pack_pkg;

    // 10-bit pixel as carried in a 16-bit beat
    typedef struct packed {
        logic [5:0] unused;
        logic [7:0] upper;      // pixel bits 9:2
        logic [1:0] lower;      // pixel bits 1:0
    } pixel_fields_t;

    // headers and unpacked data use word, packed mode uses pixel
    typedef union packed {
        logic [`RAW_WIDTH-1:0] word;
        pixel_fields_t         pixel;
    } raw_data_u;

    // input beat, 21 bits
    typedef struct packed {
        logic [`LANE_WIDTH-1:0]  lane;
        logic [`DTYPE_WIDTH-1:0] dtype;
        raw_data_u               data;
    } raw_beat_t;

    // output word, 37 bits
    typedef struct packed {
        logic [`LANE_WIDTH-1:0]  lane;
        logic [`DTYPE_WIDTH-1:0] dtype;
        logic [`WORD_WIDTH-1:0]  data;
    } packed_word_t;

endpackage

`default_nettype wire

//--- rtl/raw_pack_top.sv
// raw stream packer top, dispatcher, four lane packers with fifos, collector
// pack_mode is per lane and must only change while that lane is idle

`timescale 1ns/100ps
`default_nettype none

`include "raw_pack_macros.svh"

module raw_pack_top
    import raw_pack_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetb,

    input  raw_beat_t             in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,

    input  logic [`RAW_WIDTH-1:0] image_type,
    input  logic                  pack_mode [`NUM_LANES],

    output packed_word_t          out_word,
    output logic                  out_valid,
    input  logic                  out_ready
);

    raw_beat_t    lane_beat;
    logic         lane_valid [`NUM_LANES];
    logic         lane_ready [`NUM_LANES];
    logic         push       [`NUM_LANES];
    packed_word_t push_word  [`NUM_LANES];
    logic         room2      [`NUM_LANES];
    logic         not_empty  [`NUM_LANES];
    packed_word_t head_words [`NUM_LANES];
    logic         pop        [`NUM_LANES];

    raw_lane_dispatch u_dispatch (
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready),
        .lane_beat  (lane_beat)
    );

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        raw_to_32 u_pack (
            .clk        (clk),
            .resetb     (resetb),
            .beat       (lane_beat),
            .beat_valid (lane_valid[g]),
            .beat_ready (lane_ready[g]),
            .pack       (pack_mode[g]),
            .image_type (image_type),
            .fifo_room  (room2[g]),
            .push       (push[g]),
            .word       (push_word[g])
        );

        lane_fifo u_fifo (
            .clk        (clk),
            .resetb     (resetb),
            .push       (push[g]),
            .push_word  (push_word[g]),
            .room2      (room2[g]),
            .pop        (pop[g]),
            .not_empty  (not_empty[g]),
            .head_word  (head_words[g])
        );
    end

    word_collector u_collect (
        .clk        (clk),
        .resetb     (resetb),
        .not_empty  (not_empty),
        .head_words (head_words),
        .pop        (pop),
        .out_word   (out_word),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

//--- rtl/raw_to_32.sv
// lane packer, 16-bit tagged beats in, 32-bit tagged words out
// pack selects 10-bit packed mode, change it only while the lane is idle

`timescale 1ns/100ps
`default_nettype none

`include "raw_pack_macros.svh"

module raw_to_32
    import raw_pack_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetb,

    input  raw_beat_t             beat,
    input  logic                  beat_valid,
    output logic                  beat_ready,

    input  logic                  pack,
    input  logic [`RAW_WIDTH-1:0] image_type,

    input  logic                  fifo_room,
    output logic                  push,
    output packed_word_t          word
);

    logic [`WORD_WIDTH-1:0]  asm_word;        // pair or upper-bit assembly
    logic [`WORD_WIDTH-1:0]  lsbs;            // collected lower pixel bits
    logic [`LANE_WIDTH-1:0]  lane_q;
    logic                    half;            // first beat of a pair held
    logic [3:0]              pix_cnt;         // packed pixels mod 16
    logic [3:0]              hdr_pos;
    logic                    flush_pending;
    logic                    row_end_pending;

    logic                    accept;
    logic                    is_header;
    logic                    is_pixel;
    logic                    pair_beat;
    logic [`RAW_WIDTH-1:0]   pair_data;

    assign beat_ready = fifo_room && !flush_pending && !row_end_pending;
    assign accept     = beat_valid && beat_ready;

    assign is_header = (beat.dtype == `DTYPE_HEADER);
    assign is_pixel  = (beat.dtype == `DTYPE_PIXEL);
    assign pair_beat = is_header || (is_pixel && !pack);   // headers always pair

    // image type substituted at one header position
    assign pair_data = (is_header && hdr_pos == 4'(`IMAGE_TYPE_POS)) ? image_type
                                                                      : beat.data.word;

    // push and word are combinational so a word leaves on its last beat's edge
    always_comb begin
        push       = 1'b0;
        word.lane  = lane_q;
        word.dtype = `DTYPE_PIXEL;
        word.data  = lsbs;
        if (flush_pending) begin
            push = fifo_room;                           // lower-bits word
        end else if (row_end_pending) begin
            push       = fifo_room;
            word.dtype = `DTYPE_ROW_END;
            word.data  = asm_word;
        end else if (accept) begin
            word.lane  = beat.lane;
            word.dtype = beat.dtype;
            if (pair_beat) begin
                push      = half;
                word.data = {pair_data, asm_word[15:0]};
            end else if (is_pixel) begin
                push      = (pix_cnt[1:0] == 2'd3);
                word.data = {beat.data.pixel.upper, asm_word[31:8]};
            end else if (pack && beat.dtype == `DTYPE_ROW_END) begin
                push       = 1'b1;                      // pending lsbs first
                word.dtype = `DTYPE_PIXEL;
                word.data  = lsbs;
            end else begin
                push      = 1'b1;
                word.data = {16'h0000, beat.data.word};
            end
        end
    end

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            half            <= 1'b0;
            pix_cnt         <= 4'd0;
            hdr_pos         <= 4'd0;
            lsbs            <= '0;
            flush_pending   <= 1'b0;
            row_end_pending <= 1'b0;
        end else begin
            if (flush_pending && fifo_room) begin
                flush_pending <= 1'b0;
                lsbs          <= '0;
            end
            if (row_end_pending && fifo_room) begin
                row_end_pending <= 1'b0;
            end
            if (accept) begin
                if (is_header) begin
                    if (hdr_pos != 4'hf) hdr_pos <= hdr_pos + 4'd1;   // saturate
                end else begin
                    hdr_pos <= 4'd0;
                end
                if (pair_beat) begin
                    half <= !half;
                end else if (is_pixel) begin
                    pix_cnt <= pix_cnt + 4'd1;
                    lsbs    <= {beat.data.pixel.lower, lsbs[31:2]};
                    if (pix_cnt == 4'd15) flush_pending <= 1'b1;
                end else begin
                    // row end or frame end closes all partial state
                    half    <= 1'b0;
                    pix_cnt <= 4'd0;
                    lsbs    <= '0;
                    if (pack && beat.dtype == `DTYPE_ROW_END) row_end_pending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lane_q <= beat.lane;
            if (pair_beat) begin
                if (!half) asm_word[15:0] <= pair_data;
            end else if (is_pixel) begin
                asm_word <= {beat.data.pixel.upper, asm_word[31:8]};
            end else begin
                asm_word <= {16'h0000, beat.data.word};  // held for deferred row end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/word_collector.sv
// round-robin merge of the lane fifos onto one registered valid/ready port
// each output word keeps the lane number it was packed with

`timescale 1ns/100ps
`default_nettype none

`include "raw_pack_macros.svh"

module word_collector
    import raw_pack_pkg::*;
(
    input  logic         clk,
    input  logic         resetb,

    input  logic         not_empty  [`NUM_LANES],
    input  packed_word_t head_words [`NUM_LANES],
    output logic         pop        [`NUM_LANES],

    output packed_word_t out_word,
    output logic         out_valid,
    input  logic         out_ready
);

    logic [`LANE_WIDTH-1:0] rr;       // lane searched first
    logic [`LANE_WIDTH-1:0] sel;
    logic [`LANE_WIDTH-1:0] idx;
    logic                   found;
    logic                   load;     // output register free this cycle

    assign load = !out_valid || out_ready;

    // first non-empty lane at or after the pointer, wraps with the lane width
    always_comb begin
        found = 1'b0;
        sel   = rr;
        idx   = rr;
        for (int k = 0; k < `NUM_LANES; k++) begin
            idx = rr + `LANE_WIDTH'(k);
            if (!found && not_empty[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
        for (int i = 0; i < `NUM_LANES; i++) begin
            pop[i] = load && found && (sel == `LANE_WIDTH'(i));
        end
    end

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            out_valid <= 1'b0;
            rr        <= '0;
        end else if (load) begin
            out_valid <= found;
            if (found) rr <= sel + 1'b1;   // next lane gets priority
        end
    end

    always_ff @(posedge clk) begin
        if (load && found) out_word <= head_words[sel];
    end

endmodule

`default_nettype wire

//--- sim/raw_pack_checker.sv
// handshake and fifo push assertions for the raw stream packer top
// attached to raw_pack_top with bind from the testbench

`timescale 1ns/100ps
`default_nettype none

`include "raw_pack_macros.svh"

module raw_pack_checker
    import raw_pack_pkg::*;
(
    input logic         clk,
    input logic         resetb,
    input packed_word_t out_word,
    input logic         out_valid,
    input logic         out_ready,
    input logic         push  [`NUM_LANES],
    input logic         room2 [`NUM_LANES]
);

    int fail_count = 0;   // assertion failures so far

    // a held word waits for the sink
    assert property (@(posedge clk) disable iff (!resetb)
        out_valid && !out_ready |=> out_valid && $stable(out_word))
    else begin
        $error("out_valid dropped or out_word changed before out_ready");
        fail_count++;
    end

    assert property (@(posedge clk) !resetb |-> !out_valid)
    else begin
        $error("out_valid high during reset");
        fail_count++;
    end

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_push
        assert property (@(posedge clk) disable iff (!resetb) push[g] |-> room2[g])
        else begin
            $error("push into lane %0d fifo without room for two words", g);
            fail_count++;
        end
    end

endmodule

`default_nettype wire

//--- sim/raw_pack_tb.sv
// table-driven testbench for the raw stream packer with a per-lane reference model
// output words are checked in lane order under random out_ready

`timescale 1ns/100ps
`default_nettype none

`include "raw_pack_macros.svh"

module raw_pack_tb
    import raw_pack_pkg::*;
();

    logic         clk = 1'b0;
    logic         resetb;
    raw_beat_t    in_beat;
    logic         in_valid;
    logic         in_ready;
    logic [15:0]  image_type;
    logic         pack_mode [`NUM_LANES];
    packed_word_t out_word;
    logic         out_valid;
    logic         out_ready;

    raw_beat_t    rows [$];                  // stimulus table
    packed_word_t exp_q [`NUM_LANES][$];     // expected words per lane
    logic [15:0]  pair_lo [`NUM_LANES] = '{default: '0};
    logic         half_q  [`NUM_LANES] = '{default: 1'b0};
    logic [31:0]  up_acc  [`NUM_LANES] = '{default: '0};
    logic [31:0]  lsb_acc [`NUM_LANES] = '{default: '0};
    int           pix_n   [`NUM_LANES] = '{default: 0};
    int           hdr_n   [`NUM_LANES] = '{default: 0};
    int           cycles = 0;
    int           cycle_limit = 0;

    always #2 clk = ~clk;

    raw_pack_top UUT (.*);

    bind raw_pack_top raw_pack_checker u_check (
        .clk(clk), .resetb(resetb), .out_word(out_word), .out_valid(out_valid),
        .out_ready(out_ready), .push(push), .room2(room2));

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic void add_row(input int lane, input logic [2:0] tag, input logic [15:0] d);
        raw_beat_t b;
        b.lane      = `LANE_WIDTH'(lane);
        b.dtype     = tag;
        b.data.word = d;
        rows.push_back(b);
    endfunction

    function automatic void expect_word(input int lane, input logic [2:0] tag,
                                        input logic [31:0] d);
        packed_word_t w;
        w.lane  = `LANE_WIDTH'(lane);
        w.dtype = tag;
        w.data  = d;
        exp_q[lane].push_back(w);
    endfunction

    function automatic int pending_words();
        int n = 0;
        foreach (exp_q[l])
            n += exp_q[l].size();
        return n;
    endfunction

    // expected words from one accepted beat
    function automatic void model_beat(input raw_beat_t b);
        int          l;
        logic [15:0] d;
        l = int'(b.lane);
        d = b.data.word;
        if (b.dtype == `DTYPE_HEADER) begin
            if (hdr_n[l] == `IMAGE_TYPE_POS)
                d = image_type;
            hdr_n[l]++;
        end else begin
            hdr_n[l] = 0;
        end
        if (b.dtype == `DTYPE_HEADER || (b.dtype == `DTYPE_PIXEL && !pack_mode[l])) begin
            if (half_q[l])
                expect_word(l, b.dtype, {d, pair_lo[l]});   // first beat in the low half
            else
                pair_lo[l] = d;
            half_q[l] = !half_q[l];
        end else if (b.dtype == `DTYPE_PIXEL) begin
            up_acc[l]  = {b.data.pixel.upper, up_acc[l][31:8]};
            lsb_acc[l] = {b.data.pixel.lower, lsb_acc[l][31:2]};
            pix_n[l]++;
            if (pix_n[l] % 4 == 0)
                expect_word(l, `DTYPE_PIXEL, up_acc[l]);
            if (pix_n[l] == 16) begin
                expect_word(l, `DTYPE_PIXEL, lsb_acc[l]);   // lower bits flush
                lsb_acc[l] = '0;
                pix_n[l]   = 0;
            end
        end else begin
            if (pack_mode[l] && b.dtype == `DTYPE_ROW_END)
                expect_word(l, `DTYPE_PIXEL, lsb_acc[l]);
            expect_word(l, b.dtype, {16'h0000, d});
            half_q[l]  = 1'b0;
            pix_n[l]   = 0;
            lsb_acc[l] = '0;
        end
    endfunction

    function automatic void build_table();
        for (int i = 0; i < 4; i++)
            add_row(0, `DTYPE_PIXEL, 16'h0100 + 16'(i));     // unpacked pairs
        for (int i = 0; i < 6; i++)
            add_row(1, `DTYPE_HEADER, 16'hc000 + 16'(i));
        for (int i = 0; i < 32; i++)
            add_row(2, `DTYPE_PIXEL, 16'($urandom));
        for (int i = 0; i < 4; i++)
            add_row(3, `DTYPE_HEADER, 16'h3a00 + 16'(i));   // headers in packed mode
        for (int i = 0; i < 8; i++)
            add_row(3, `DTYPE_PIXEL, 16'($urandom));
        add_row(3, `DTYPE_ROW_END, 16'h00e1);
        add_row(3, `DTYPE_FRAME_END, 16'h00f1);
        // interleaved lanes
        for (int i = 0; i < 64; i++)
            add_row(i % `NUM_LANES, `DTYPE_PIXEL, 16'($urandom));
        for (int l = 0; l < `NUM_LANES; l++)
            add_row(l, `DTYPE_FRAME_END, 16'hf000 + 16'(l));
    endfunction

    task automatic send_row(input raw_beat_t b);
        in_beat  = b;
        in_valid = 1'b1;
        do
            @(posedge clk);
        while (!in_ready);
        model_beat(b);
        @(negedge clk);
    endtask

    always @(negedge clk)
        out_ready = ($urandom % 100) < 70;

    always @(posedge clk) begin
        packed_word_t w;
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit)
            fail_run($sformatf("timeout after %0d cycles", cycles));
        assert (UUT.u_check.fail_count == 0)
            else fail_run("a handshake assertion on the top level fired");
        if (resetb && out_valid && out_ready) begin
            assert (exp_q[out_word.lane].size() != 0)
                else fail_run($sformatf("unexpected word on lane %0d", out_word.lane));
            w = exp_q[out_word.lane].pop_front();
            assert (out_word == w)
                else fail_run($sformatf("MISMATCH time %0t: lane %0d expected %h got %h",
                                        $time, w.lane, w, out_word));
        end
    end

    initial begin
        void'($urandom(32'h6db80f0c));
        resetb     = 1'b0;
        in_valid   = 1'b0;
        in_beat    = '0;
        out_ready  = 1'b0;
        image_type = 16'h2b5c;
        for (int l = 0; l < `NUM_LANES; l++)
            pack_mode[l] = (l >= 2);   // lanes 2 and 3 packed
        build_table();
        cycle_limit = rows.size() * 8 + 200;
        repeat (4) @(negedge clk);
        resetb = 1'b1;
        foreach (rows[i])
            send_row(rows[i]);
        in_valid = 1'b0;
        for (int n = 0; n < 200 && pending_words() != 0; n++)
            @(posedge clk);
        repeat (8) @(posedge clk);   // lets any stray extra word show up
        @(negedge clk);
        if (pending_words() == 0 && UUT.u_check.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run($sformatf("%0d expected words never came out, %0d assertion failures",
                               pending_words(), UUT.u_check.fail_count));
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
rtl/raw_pack_pkg.sv
rtl/raw_lane_dispatch.sv
rtl/raw_to_32.sv
rtl/lane_fifo.sv
rtl/word_collector.sv
rtl/raw_pack_top.sv
sim/raw_pack_checker.sv
sim/raw_pack_tb.sv
